//--- src/mini_core_consts.svh
/* Core-wide constants: boot address, register count
   and the RV32I major opcodes that the core decodes */

`ifndef MINI_CORE_CONSTS_SVH
`define MINI_CORE_CONSTS_SVH

// Program counter after reset
`define MC_BOOT_ADDR 32'h0000_0080

// Architectural integer registers
`define MC_NUM_REGS 32

// Major opcodes, instruction bits [6:0]
`define MC_OP_REG    7'b0110011
`define MC_OP_IMM    7'b0010011
`define MC_OP_LUI    7'b0110111
`define MC_OP_BRANCH 7'b1100011
`define MC_OP_JAL    7'b1101111

`endif

//--- src/mini_core_pkg.sv
/* Instruction format views and union, operation kinds,
   fetch, decode and retirement records */

package mini_core_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Branch offset bits are scattered around the register fields
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_LUI,
    OP_BEQ,
    OP_JAL,
    OP_ILLEGAL
  } op_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_u      instr;
  } fetch_t;

  typedef struct packed {
    op_e         op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        use_imm;
    logic [31:0] pc;
  } dec_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [31:0] rd_wdata;
    logic        trap;
  } retire_t;

endpackage

//--- src/mini_core_fetch.sv
/* Instruction fetch: program counter and the
   request/grant/rvalid bus state machine */

`include "mini_core_consts.svh"

module mini_core_fetch import mini_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        done_i,
  input  logic [31:0] next_pc_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  output fetch_t      fetch_o
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic [31:0]  pc_q;
  logic         valid_q;
  logic         capture;
  instr_u       instr_q;

  // IDLE is left at the latest in the cycle the word is handed on,
  // so the next request lines up with the retire cycle
  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_IDLE: begin
        if (fetch_enable_i) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  assign capture = (state_q == FETCH_WAIT) && instr_rvalid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH_IDLE;
      pc_q    <= `MC_BOOT_ADDR;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= capture;
      if (done_i) begin
        pc_q <= next_pc_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = (state_q == FETCH_REQ);
  // Retire cycle carries the new target before pc_q has taken it
  assign instr_addr_o = done_i ? next_pc_i : pc_q;

  // pc_q still holds the fetched address while the word is valid
  assign fetch_o = '{valid: valid_q, pc: pc_q, instr: instr_q};

endmodule

//--- src/mini_core_decode.sv
/* Instruction decoder: operation kind, register
   indices and sign-extended immediate */

`include "mini_core_consts.svh"

module mini_core_decode import mini_core_pkg::*; (
  input  fetch_t fetch_i,
  output dec_t   dec_o
);

  instr_u ins;

  assign ins = fetch_i.instr;

  always_comb begin
    dec_o.op      = OP_ILLEGAL;
    dec_o.rs1     = ins.r.rs1;
    dec_o.rs2     = ins.r.rs2;
    dec_o.rd      = ins.r.rd;
    dec_o.imm     = '0;
    dec_o.use_imm = 1'b0;
    dec_o.pc      = fetch_i.pc;

    case (ins.r.opcode)
      `MC_OP_REG: begin
        if (ins.r.funct3 == 3'b000 && ins.r.funct7 == 7'b0000000) begin
          dec_o.op = OP_ADD;
        end else if (ins.r.funct3 == 3'b000 && ins.r.funct7 == 7'b0100000) begin
          dec_o.op = OP_SUB;
        end else if (ins.r.funct3 == 3'b100 && ins.r.funct7 == 7'b0000000) begin
          dec_o.op = OP_XOR;
        end
      end
      `MC_OP_IMM: begin
        // ADDI only
        if (ins.i.funct3 == 3'b000) begin
          dec_o.op      = OP_ADD;
          dec_o.use_imm = 1'b1;
          dec_o.imm     = {{20{ins.i.imm12[11]}}, ins.i.imm12};
        end
      end
      `MC_OP_LUI: begin
        dec_o.op      = OP_LUI;
        dec_o.use_imm = 1'b1;
        // Upper 20 bits span imm12, rs1 and funct3 of the I view
        dec_o.imm     = {ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'b0};
      end
      `MC_OP_BRANCH: begin
        if (ins.b.funct3 == 3'b000) begin
          dec_o.op  = OP_BEQ;
          dec_o.imm = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                       ins.b.imm10_5, ins.b.imm4_1, 1'b0};
        end
      end
      `MC_OP_JAL: begin
        dec_o.op  = OP_JAL;
        dec_o.imm = {{11{ins.j.imm20}}, ins.j.imm20, ins.j.imm19_12,
                     ins.j.imm11, ins.j.imm10_1, 1'b0};
      end
      default: begin
        dec_o.op = OP_ILLEGAL;
      end
    endcase
  end

endmodule

//--- src/mini_core_regfile.sv
/* Integer register file, two read ports and one write port */

`include "mini_core_consts.svh"

module mini_core_regfile (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  input  logic [4:0]  waddr_i,
  input  logic        we_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  logic [31:0] rf_q [`MC_NUM_REGS];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < `MC_NUM_REGS; r++) begin
        rf_q[r] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      rf_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is hard-wired to zero
  assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : rf_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : rf_q[raddr_b_i];

endmodule

//--- src/mini_core_exec.sv
/* Execute stage: ALU, branch and jump target, register
   writeback, retirement record and alert */

module mini_core_exec import mini_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        valid_i,
  input  dec_t        dec_i,
  input  instr_u      instr_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output logic        rf_we_o,
  output logic [4:0]  rf_waddr_o,
  output logic [31:0] rf_wdata_o,
  output logic [31:0] next_pc_o,
  output logic        done_o,
  output retire_t     retire_o,
  output logic        alert_o
);

  logic [31:0] alu_b;
  logic [31:0] pc_plus4;
  logic [31:0] target;
  logic [31:0] result;
  logic [31:0] next_pc;
  logic        writes_rd;
  logic        wr_en;
  logic        trap;
  logic [31:0] next_pc_q;
  retire_t     retire_q;

  assign pc_plus4 = dec_i.pc + 32'd4;
  assign target   = dec_i.pc + dec_i.imm;
  assign alu_b    = dec_i.use_imm ? dec_i.imm : rs2_data_i;

  always_comb begin
    result    = '0;
    writes_rd = 1'b0;
    trap      = 1'b0;
    next_pc   = pc_plus4;
    case (dec_i.op)
      OP_ADD: begin
        result    = rs1_data_i + alu_b;
        writes_rd = 1'b1;
      end
      OP_SUB: begin
        result    = rs1_data_i - alu_b;
        writes_rd = 1'b1;
      end
      OP_XOR: begin
        result    = rs1_data_i ^ alu_b;
        writes_rd = 1'b1;
      end
      OP_LUI: begin
        result    = dec_i.imm;
        writes_rd = 1'b1;
      end
      OP_BEQ: begin
        if (rs1_data_i == rs2_data_i) begin
          next_pc = target;
        end
      end
      OP_JAL: begin
        result    = pc_plus4;
        writes_rd = 1'b1;
        next_pc   = target;
      end
      default: begin
        trap = 1'b1;
      end
    endcase
  end

  // Writes to x0 are dropped and retire as rd = 0
  assign wr_en      = writes_rd && (dec_i.rd != 5'd0);
  assign rf_we_o    = valid_i && wr_en;
  assign rf_waddr_o = dec_i.rd;
  assign rf_wdata_o = result;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_q <= '0;
    end else begin
      retire_q.valid <= valid_i;
      if (valid_i) begin
        retire_q.pc       <= dec_i.pc;
        retire_q.instr    <= instr_i;
        retire_q.rd       <= wr_en ? dec_i.rd : 5'd0;
        retire_q.rd_wdata <= wr_en ? result : 32'd0;
        retire_q.trap     <= trap;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      next_pc_q <= next_pc;
    end
  end

  assign next_pc_o = next_pc_q;
  assign done_o    = retire_q.valid;
  assign retire_o  = retire_q;
  assign alert_o   = retire_q.valid && retire_q.trap;

endmodule

//--- src/mini_core_top.sv
/* Core top level: fetch, decode, register file and execute */

module mini_core_top import mini_core_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        fetch_enable_i,
  output logic        instr_req_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  output logic [31:0] instr_addr_o,
  input  logic [31:0] instr_rdata_i,
  output retire_t     retire_o,
  output logic        alert_o
);

  fetch_t      fetch;
  dec_t        dec;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        rf_we;
  logic [4:0]  rf_waddr;
  logic [31:0] rf_wdata;
  logic [31:0] next_pc;
  logic        done;

  mini_core_fetch u_fetch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .done_i         (done),
    .next_pc_i      (next_pc),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .fetch_o        (fetch)
  );

  mini_core_decode u_decode (
    .fetch_i (fetch),
    .dec_o   (dec)
  );

  mini_core_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .waddr_i   (rf_waddr),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  mini_core_exec u_exec (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (fetch.valid),
    .dec_i      (dec),
    .instr_i    (fetch.instr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .next_pc_o  (next_pc),
    .done_o     (done),
    .retire_o   (retire_o),
    .alert_o    (alert_o)
  );

endmodule

//--- tests/mini_core_props.sv
/* Bus protocol and alert assertions, bound to the core top */

module mini_core_props import mini_core_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        instr_req_i,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic [31:0] instr_addr_i,
  input retire_t     retire_i,
  input logic        alert_i
);

  logic outstanding_q;

  // Granted request still waiting for its response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else $error("instruction request dropped or address changed before grant");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_rvalid_i |-> outstanding_q)
    else $error("rvalid arrived with no granted request outstanding");

  // Trapped instruction retires without a register write
  alert_with_trap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alert_i |-> retire_i.valid && retire_i.trap && retire_i.rd == 5'd0 &&
                retire_i.rd_wdata == 32'd0)
    else $error("alert raised without a trapped retire record that writes nothing");

  alert_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alert_i |=> !alert_i)
    else $error("alert held high for more than one cycle");

endmodule

bind mini_core_top mini_core_props mini_core_props_inst (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .instr_req_i    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .instr_addr_i   (instr_addr_o),
  .retire_i       (retire_o),
  .alert_i        (alert_o)
);

//--- tests/mini_core_tb_top.sv
/* Core testbench: clock, reset, instruction memory with random grant
   and rvalid delays, retire trace and alert checks, timeout */

module mini_core_tb_top import mini_core_pkg::*; ();

  localparam int RESET_CYCLES   = 8;
  localparam int ENABLE_DROP_AT = 12;
  localparam int QUIET_CYCLES   = 30;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        trap;
  } exp_rec_t;

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        instr_req;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  retire_t     retire;
  logic        alert;

  logic [31:0] mem [logic [31:0]];
  exp_rec_t    exp_q [$];
  string       name_q [$];
  int          n_exp;
  int          exp_idx;
  int          mismatches;
  int          other_errors;
  int          cycles;
  int          limit;
  logic        timed_out;
  logic [31:0] lfsr_q;

  // Memory model state
  logic        pending;
  logic        gnt_armed;
  int          gnt_wait;
  int          rv_wait;
  logic [31:0] pend_addr;

  // 0 running, 1 draining, 2 quiet, 3 resumed
  int          en_phase;
  int          quiet;

  mini_core_top mini_core_top_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .retire_o       (retire),
    .alert_o        (alert)
  );

  always #2 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
  endtask

  // Unloaded words return a pattern built from the full address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
  endfunction

  task automatic load_tests();
    int          fd;
    int          n;
    int          rd_v;
    int          trap_v;
    string       line;
    string       nm;
    logic [31:0] a;
    logic [31:0] w;
    exp_rec_t    rec;
    fd = $fopen("tests/mini_core_tests.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("cannot open tests/mini_core_tests.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line[0] == "M") begin
          n = $sscanf(line, "M %h %h", a, w);
          if (n == 2) begin
            mem[a] = w;
          end else begin
            other_errors++;
            $display("malformed memory line in test file: %s", line);
          end
        end else if (line[0] == "E") begin
          n = $sscanf(line, "E %s %h %d %h %d", nm, a, rd_v, w, trap_v);
          if (n == 5) begin
            rec.pc    = a;
            rec.rd    = rd_v[4:0];
            rec.wdata = w;
            rec.trap  = trap_v[0];
            exp_q.push_back(rec);
            name_q.push_back(nm);
          end else begin
            other_errors++;
            $display("malformed expected line in test file: %s", line);
          end
        end else if (line[0] != "#" && line[0] != "\n") begin
          other_errors++;
          $display("unrecognized line in test file: %s", line);
        end
      end
      $fclose(fd);
    end
    n_exp = exp_q.size();
    if (n_exp == 0) begin
      other_errors++;
      $display("test file holds no expected retire records");
    end
  endtask

  task automatic compare_field(input string test, input string field,
                               input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      mismatches++;
      $display("mismatch %s %s: expected %h, actual %h", test, field, exp_v, act_v);
    end
  endtask

  task automatic check_retire();
    exp_rec_t exp_r;
    string    nm;
    if (retire.valid) begin
      if (en_phase == 2) begin
        other_errors++;
        $display("retire at pc %h while fetch was disabled", retire.pc);
      end
      if (exp_idx < n_exp) begin
        exp_r = exp_q[exp_idx];
        nm    = name_q[exp_idx];
        compare_field(nm, "pc", exp_r.pc, retire.pc);
        compare_field(nm, "instr", read_word(exp_r.pc), retire.instr);
        compare_field(nm, "rd", 32'(exp_r.rd), 32'(retire.rd));
        compare_field(nm, "rd_wdata", exp_r.wdata, retire.rd_wdata);
        compare_field(nm, "trap", 32'(exp_r.trap), 32'(retire.trap));
        compare_field(nm, "alert", 32'(exp_r.trap), 32'(alert));
        exp_idx++;
      end
    end else if (alert) begin
      other_errors++;
      $display("alert raised without a retire record");
    end
  endtask

  // Grant after 0 to 3 cycles, response 1 to 3 cycles after grant
  task automatic serve_bus();
    int d;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    if (pending) begin
      if (rv_wait == 0) begin
        if (!mem.exists(pend_addr)) begin
          other_errors++;
          $display("fetch from unloaded address %h", pend_addr);
        end
        instr_rvalid = 1'b1;
        instr_rdata  = read_word(pend_addr);
        pending      = 1'b0;
      end else begin
        rv_wait--;
      end
    end else if (instr_req) begin
      if (!gnt_armed) begin
        draw_bits(2, gnt_wait);
        gnt_armed = 1'b1;
      end
      if (gnt_wait == 0) begin
        instr_gnt = 1'b1;
        pend_addr = instr_addr;
        pending   = 1'b1;
        gnt_armed = 1'b0;
        d = 0;
        while (d == 0) begin
          draw_bits(2, d);
        end
        rv_wait = d - 1;
      end else begin
        gnt_wait--;
      end
    end
  endtask

  task automatic control_enable();
    case (en_phase)
      0: begin
        if (exp_idx == ENABLE_DROP_AT) begin
          fetch_enable = 1'b0;
          en_phase     = 1;
        end
      end
      1: begin
        // Request already on the bus still retires
        if (exp_idx == ENABLE_DROP_AT + 1) begin
          en_phase = 2;
          quiet    = 0;
        end
      end
      2: begin
        if (instr_req) begin
          other_errors++;
          $display("fetch request issued while fetch was disabled");
        end
        quiet++;
        if (quiet == QUIET_CYCLES) begin
          fetch_enable = 1'b1;
          en_phase     = 3;
        end
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    lfsr_q       = 32'h416f;
    exp_idx      = 0;
    mismatches   = 0;
    other_errors = 0;
    cycles       = 0;
    timed_out    = 1'b0;
    pending      = 1'b0;
    gnt_armed    = 1'b0;
    gnt_wait     = 0;
    rv_wait      = 0;
    pend_addr    = '0;
    en_phase     = 0;
    quiet        = 0;
    load_tests();
    limit = n_exp * 12 + 100;

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (instr_req || retire.valid || alert) begin
        other_errors++;
        $display("request, retire or alert active during reset");
      end
    end
    rst_n        = 1'b1;
    fetch_enable = 1'b1;

    while (exp_idx < n_exp && !timed_out) begin
      @(negedge clk);
      check_retire();
      serve_bus();
      control_enable();
      cycles++;
      if (cycles > limit) begin
        timed_out = 1'b1;
        other_errors++;
        $display("timeout after %0d cycles with %0d of %0d records retired",
                 cycles, exp_idx, n_exp);
      end
    end

    $display("retired %0d of %0d records, %0d mismatches, %0d other errors",
             exp_idx, n_exp, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tests/mini_core_tests.txt
# M <address hex> <instruction word hex>
# E <test name> <pc hex> <rd decimal> <rd_wdata hex> <trap 0 or 1>
M 00000080 00700093
M 00000084 ffd00113
M 00000088 002081b3
M 0000008c 40208233
M 00000090 0020c2b3
M 00000094 00308013
M 00000098 00100333
M 0000009c 123453b7
M 000000a0 fffff437
M 000000a4 00608463
M 000000a8 00100493
M 000000ac 00208463
M 000000b0 00c0056f
M 000000b4 00200493
M 000000b8 00300493
M 000000bc ffffffff
M 000000c0 001f85b3
M 000000c4 02108633
M 000000c8 001606b3
M 000000cc 00108093
M 000000d0 00408463
M 000000d4 ff9ff06f
M 000000d8 0000006f
# Retire records in program order
E addi_pos 00000080 1 00000007 0
E addi_neg 00000084 2 fffffffd 0
E add 00000088 3 00000004 0
E sub 0000008c 4 0000000a 0
E xor 00000090 5 fffffffa 0
E addi_to_x0 00000094 0 00000000 0
E x0_reads_zero 00000098 6 00000007 0
E lui 0000009c 7 12345000 0
E lui_upper_bit 000000a0 8 fffff000 0
E beq_taken 000000a4 0 00000000 0
E beq_not_taken 000000ac 0 00000000 0
E jal_link 000000b0 10 000000b4 0
E illegal_opcode 000000bc 0 00000000 1
E illegal_no_write 000000c0 11 00000007 0
E illegal_funct7 000000c4 0 00000000 1
E illegal_funct7_no_write 000000c8 13 00000007 0
E loop_inc_8 000000cc 1 00000008 0
E loop_beq_1 000000d0 0 00000000 0
E loop_back_1 000000d4 0 00000000 0
E loop_inc_9 000000cc 1 00000009 0
E loop_beq_2 000000d0 0 00000000 0
E loop_back_2 000000d4 0 00000000 0
E loop_inc_10 000000cc 1 0000000a 0
E loop_exit_beq 000000d0 0 00000000 0
E self_loop 000000d8 0 00000000 0

//--- src.f
+incdir+src
src/mini_core_pkg.sv
src/mini_core_fetch.sv
src/mini_core_decode.sv
src/mini_core_regfile.sv
src/mini_core_exec.sv
src/mini_core_top.sv
tests/mini_core_props.sv
tests/mini_core_tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module mini_core_tb_top -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmini_core_tb_top > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Done: errors found" "$log_file"; then
  exit 1
fi
exit 0
